/* hdl/rf_trig_finder.sv */
`timescale 1ns/10ps
`default_nettype none

module rf_trig_finder import trig_pkg::*; (
    input  wire logic              sys_clk,
    input  wire logic              runrst,
    input  wire logic [TIME_W-1:0] cur_time_i,
    input  surf_word_u             trig_dat_i [NSURF],
    input  wire logic              trig_dat_valid_i,
    input  wire logic [NSURF-1:0]  surf_mask_i,
    trig_event_if.producer         evt
);

    // unmasked boards with the header flag up
    logic [NSURF-1:0]      hit_vec;
    logic                  sel_hit;
    logic [SURF_IDX_W-1:0] sel_idx;
    surf_word_u            sel_word;
    // second state of the sequencer, metadata frame expected
    logic                  meta_wait_q;
    logic                  evt_free;
    logic                  hdr_start;
    logic                  meta_done;

    always_comb begin
        for (int i = 0; i < NSURF; i++) begin
            hit_vec[i] = trig_dat_i[i].hdr.flag & ~surf_mask_i[i];
        end
    end

    // lowest index wins, so scan downward
    always_comb begin
        sel_hit = 1'b0;
        sel_idx = '0;
        for (int i = NSURF - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                sel_hit = 1'b1;
                sel_idx = i[SURF_IDX_W-1:0];
            end
        end
    end

    assign sel_word = trig_dat_i[sel_idx];

    // slot is free when empty or being taken this cycle
    assign evt_free = ~evt.evt_valid | evt.evt_take;

    // header only accepted at frame start while idle
    assign hdr_start = ~meta_wait_q & trig_dat_valid_i & sel_hit & evt_free;
    // next frame carries the metadata
    assign meta_done = meta_wait_q & trig_dat_valid_i;

    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            meta_wait_q   <= 1'b0;
            evt.evt_valid <= 1'b0;
        end else begin
            if (hdr_start) begin
                meta_wait_q <= 1'b1;
            end else if (meta_done) begin
                meta_wait_q <= 1'b0;
            end
            // present after metadata, drop on take
            if (meta_done) begin
                evt.evt_valid <= 1'b1;
            end else if (evt.evt_take) begin
                evt.evt_valid <= 1'b0;
            end
        end
    end

    // event payload
    always_ff @(posedge sys_clk) begin
        if (hdr_start) begin
            // subtick refines time within the frame
            evt.evt_time <= cur_time_i + TIME_W'(sel_word.hdr.subtick);
            evt.evt_surf <= sel_idx;
            evt.evt_beam <= sel_word.hdr.beam;
        end
        if (meta_done) begin
            // same board as the header
            evt.evt_info <= trig_dat_i[evt.evt_surf].meta.info;
        end
    end

endmodule

`default_nettype wire

/* hdl/soft_trig_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module soft_trig_gen import trig_pkg::*; (
    input  wire logic                sys_clk,
    input  wire logic                runrst,
    input  wire logic [TIME_W-1:0]   cur_time_i,
    input  wire logic                soft_trig_i,
    input  wire logic [PERIOD_W-1:0] soft_period_i,
    trig_event_if.producer           evt
);

    // period in use, and cycles left until expiry
    logic [PERIOD_W-1:0] period_q;
    logic [PERIOD_W-1:0] cnt_q;
    logic                period_fire;
    logic                req;
    logic                evt_free;

    // no expiry on the cycle the period changes
    assign period_fire = (period_q != '0) && (cnt_q == '0) && (soft_period_i == period_q);
    assign req         = soft_trig_i | period_fire;
    assign evt_free    = ~evt.evt_valid | evt.evt_take;

    // software events have no board or beam
    assign evt.evt_surf = '0;
    assign evt.evt_beam = '0;

    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            period_q      <= '0;
            cnt_q         <= '0;
            evt.evt_valid <= 1'b0;
        end else begin
            // restart count on any period change
            if (soft_period_i != period_q) begin
                period_q <= soft_period_i;
                cnt_q    <= soft_period_i - 1'b1;
            end else if (period_fire) begin
                cnt_q <= period_q - 1'b1;
            end else if (period_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            // requests while held are lost
            if (req && evt_free) begin
                evt.evt_valid <= 1'b1;
            end else if (evt.evt_take) begin
                evt.evt_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (req && evt_free) begin
            evt.evt_time <= cur_time_i;
            // manual beats periodic
            evt.evt_info <= soft_trig_i ? INFO_MANUAL : INFO_PERIODIC;
        end
    end

endmodule

`default_nettype wire

/* hdl/trig_event_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one timestamped event, finder to merger
interface trig_event_if import trig_pkg::*; ();

    logic                  evt_valid;
    logic [TIME_W-1:0]     evt_time;
    logic [SURF_IDX_W-1:0] evt_surf;
    logic [BEAM_W-1:0]     evt_beam;
    logic [INFO_W-1:0]     evt_info;
    // one cycle per accepted event
    logic                  evt_take;

    modport producer (
        output evt_valid, evt_time, evt_surf, evt_beam, evt_info,
        input  evt_take
    );

    modport consumer (
        input  evt_valid, evt_time, evt_surf, evt_beam, evt_info,
        output evt_take
    );

endinterface

`default_nettype wire

/* hdl/trig_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module trig_merge import trig_pkg::*; (
    input  wire logic             sys_clk,
    input  wire logic             runrst,
    trig_event_if.consumer        rf_evt,
    trig_event_if.consumer        soft_evt,
    input  wire logic             credit_i,
    output logic                  trig_valid_o,
    output logic [REC_W-1:0]      trig_rec_o
);

    // credits held by the sender
    logic [CREDIT_W-1:0]   credit_q;
    logic [SEQ_W-1:0]      seq_q;
    logic                  can_send;
    logic                  rf_sel;
    logic                  soft_sel;
    logic                  take_any;
    // chosen event
    logic                  pick_src;
    logic [TIME_W-1:0]     pick_time;
    logic [SURF_IDX_W-1:0] pick_surf;
    logic [BEAM_W-1:0]     pick_beam;
    logic [INFO_W-1:0]     pick_info;
    logic [REC_W-1:0]      rec_nxt;
    logic [REC_W-1:0]      rec_q;

    // record in flight still owns a credit
    assign can_send = credit_q > CREDIT_W'(trig_valid_o);

    // rf has priority
    assign rf_sel   = rf_evt.evt_valid & can_send;
    assign soft_sel = soft_evt.evt_valid & can_send & ~rf_evt.evt_valid;
    assign take_any = rf_sel | soft_sel;

    assign rf_evt.evt_take   = rf_sel;
    assign soft_evt.evt_take = soft_sel;

    always_comb begin
        if (rf_sel) begin
            pick_src  = SRC_RF;
            pick_time = rf_evt.evt_time;
            pick_surf = rf_evt.evt_surf;
            pick_beam = rf_evt.evt_beam;
            pick_info = rf_evt.evt_info;
        end else begin
            pick_src  = SRC_SOFT;
            pick_time = soft_evt.evt_time;
            pick_surf = soft_evt.evt_surf;
            pick_beam = soft_evt.evt_beam;
            pick_info = soft_evt.evt_info;
        end
    end

    // pack the record
    always_comb begin
        rec_nxt = '0;
        rec_nxt[REC_SEQ_LSB +: SEQ_W]       = seq_q;
        rec_nxt[REC_SRC_BIT]                = pick_src;
        rec_nxt[REC_SURF_LSB +: SURF_IDX_W] = pick_surf;
        rec_nxt[REC_BEAM_LSB +: BEAM_W]     = pick_beam;
        rec_nxt[REC_INFO_LSB +: INFO_W]     = pick_info;
        rec_nxt[REC_TIME_LSB +: TIME_W]     = pick_time;
    end

    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            credit_q     <= CREDIT_W'(CREDIT_MAX);
            seq_q        <= '0;
            trig_valid_o <= 1'b0;
        end else begin
            trig_valid_o <= take_any;
            // wraps mod 16
            if (take_any) begin
                seq_q <= seq_q + 1'b1;
            end
            // spend on output, return on credit_i, both cancel
            case ({trig_valid_o, credit_i})
                2'b10: credit_q <= credit_q - 1'b1;
                2'b01: begin
                    // saturate at the grant
                    if (credit_q < CREDIT_W'(CREDIT_MAX)) begin
                        credit_q <= credit_q + 1'b1;
                    end
                end
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take_any) begin
            rec_q <= rec_nxt;
        end
    end

    assign trig_rec_o = rec_q;

endmodule

`default_nettype wire

/* hdl/trig_pkg.sv */
`default_nettype none

package trig_pkg;

    // board and frame geometry
    localparam int NSURF      = 8;
    localparam int SURF_IDX_W = 3;
    localparam int WORD_W     = 16;
    localparam int NPHASE     = 4;

    // event field widths
    localparam int TIME_W   = 32;
    localparam int BEAM_W   = 12;
    localparam int INFO_W   = 12;
    localparam int PERIOD_W = 16;

    // record and output flow control
    localparam int REC_W      = 64;
    localparam int CREDIT_MAX = 4;
    localparam int CREDIT_W   = 3;
    localparam int SEQ_W      = 4;

    // record field positions, lsb of each field
    localparam int REC_SEQ_LSB  = 60;
    localparam int REC_SRC_BIT  = 59;
    localparam int REC_SURF_LSB = 56;
    localparam int REC_BEAM_LSB = 44;
    localparam int REC_INFO_LSB = 32;
    localparam int REC_TIME_LSB = 0;

    // source codes
    localparam logic SRC_SOFT = 1'b0;
    localparam logic SRC_RF   = 1'b1;

    // info values carried by software events
    localparam logic [INFO_W-1:0] INFO_MANUAL   = 12'd0;
    localparam logic [INFO_W-1:0] INFO_PERIODIC = 12'd1;

    // one surf word, header in one frame and metadata in the next
    typedef union packed {
        struct packed {
            logic              flag;
            logic [2:0]        subtick;
            logic [BEAM_W-1:0] beam;
        } hdr;
        struct packed {
            logic [WORD_W-INFO_W-1:0] rsvd;
            logic [INFO_W-1:0]        info;
        } meta;
    } surf_word_u;

endpackage

`default_nettype wire

/* hdl/trig_top.sv */
`timescale 1ns/10ps
`default_nettype none

module trig_top import trig_pkg::*; (
    input  wire logic                sys_clk,
    input  wire logic                runrst,
    input  wire logic [TIME_W-1:0]   cur_time_i,
    // one word per board, held for the frame
    input  surf_word_u               trig_dat_i [NSURF],
    input  wire logic                trig_dat_valid_i,
    // 1 masks a board
    input  wire logic [NSURF-1:0]    surf_mask_i,
    input  wire logic                soft_trig_i,
    input  wire logic [PERIOD_W-1:0] soft_period_i,
    input  wire logic                credit_i,
    output logic                     trig_valid_o,
    output logic [REC_W-1:0]         trig_rec_o
);

    // finder to merger links
    trig_event_if rf_evt_if ();
    trig_event_if soft_evt_if ();

    // rf trigger path
    rf_trig_finder i_rf_trig_finder (
        .sys_clk          (sys_clk),
        .runrst           (runrst),
        .cur_time_i       (cur_time_i),
        .trig_dat_i       (trig_dat_i),
        .trig_dat_valid_i (trig_dat_valid_i),
        .surf_mask_i      (surf_mask_i),
        .evt              (rf_evt_if.producer)
    );

    // manual and periodic triggers
    soft_trig_gen i_soft_trig_gen (
        .sys_clk       (sys_clk),
        .runrst        (runrst),
        .cur_time_i    (cur_time_i),
        .soft_trig_i   (soft_trig_i),
        .soft_period_i (soft_period_i),
        .evt           (soft_evt_if.producer)
    );

    // numbered records out under credits
    trig_merge i_trig_merge (
        .sys_clk      (sys_clk),
        .runrst       (runrst),
        .rf_evt       (rf_evt_if.consumer),
        .soft_evt     (soft_evt_if.consumer),
        .credit_i     (credit_i),
        .trig_valid_o (trig_valid_o),
        .trig_rec_o   (trig_rec_o)
    );

endmodule

`default_nettype wire

/* list.f */
hdl/trig_pkg.sv
hdl/trig_event_if.sv
hdl/rf_trig_finder.sv
hdl/soft_trig_gen.sv
hdl/trig_merge.sv
hdl/trig_top.sv
tests/trig_tb_asserts.sv
tests/trig_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module trig_tb \
    -o trig_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/trig_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* tests/trig_input.txt */
# name frames mask flags subtick beam info manual period nper hold exp_n exp_surf
# mask, flags, beam and info in hex; board i gets beam+i and info+i
sel_lowest 3 04 2c 2 100 a00 0 0 0 0 1 3
masked_only 3 0f 05 1 200 b00 0 0 0 0 0 0
manual 3 00 00 0 000 000 1 0 0 0 1 0
periodic 14 00 00 0 000 000 0 10 5 0 5 0
rf_and_soft 3 00 c0 3 300 c00 1 0 0 0 2 6
credit_hold 14 00 00 0 000 000 0 6 8 1 5 0
periodic_b 8 00 00 0 000 000 0 7 4 0 4 0
rf_b 3 01 03 1 040 0d0 1 0 0 0 2 1

/* tests/trig_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module trig_tb import trig_pkg::*; ();

    logic                sys_clk;
    logic                runrst;
    logic [TIME_W-1:0]   cur_time;
    surf_word_u          trig_dat [NSURF];
    logic                trig_dat_valid;
    logic [NSURF-1:0]    surf_mask;
    logic                soft_trig;
    logic [PERIOD_W-1:0] soft_period;
    logic                credit_ret;
    logic                trig_valid;
    logic [REC_W-1:0]    trig_rec;

    // test table from the data file
    logic [8*16-1:0]     t_name [16];
    logic [7:0]          t_mask [16];
    logic [7:0]          t_flags [16];
    logic [11:0]         t_beam [16];
    logic [11:0]         t_info [16];
    int t_frames [16], t_sub [16], t_man [16], t_per [16];
    int t_nper [16], t_hold [16], t_exp [16], t_surf [16];
    int n_tests, err_cnt, rec_cnt, test_got, release_cnt, cyc_cnt, cyc_limit;
    logic                hold_credit;
    logic [31:0]         lcg_state;
    logic [REC_W-1:0]    exp_q [$];
    logic [REC_W-1:0]    exp_rec;

    trig_top i_trig_top (
        .sys_clk          (sys_clk),
        .runrst           (runrst),
        .cur_time_i       (cur_time),
        .trig_dat_i       (trig_dat),
        .trig_dat_valid_i (trig_dat_valid),
        .surf_mask_i      (surf_mask),
        .soft_trig_i      (soft_trig),
        .soft_period_i    (soft_period),
        .credit_i         (credit_ret),
        .trig_valid_o     (trig_valid),
        .trig_rec_o       (trig_rec)
    );

    initial sys_clk = 1'b0;
    always #50 sys_clk = ~sys_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected record from the field map, seq filled in on arrival
    function automatic logic [REC_W-1:0] make_rec(input logic src,
            input logic [SURF_IDX_W-1:0] surf, input logic [BEAM_W-1:0] beam,
            input logic [INFO_W-1:0] info, input logic [TIME_W-1:0] tm);
        logic [REC_W-1:0] r;
        r = '0;
        r[REC_SRC_BIT]                = src;
        r[REC_SURF_LSB +: SURF_IDX_W] = surf;
        r[REC_BEAM_LSB +: BEAM_W]     = beam;
        r[REC_INFO_LSB +: INFO_W]     = info;
        r[REC_TIME_LSB +: TIME_W]     = tm;
        return r;
    endfunction

    task automatic compare_field(input string fname, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t trig_rec_o.%0s got %0h exp %0h", $time, fname, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_rec(input logic [REC_W-1:0] got, input logic [REC_W-1:0] exp);
        compare_field("seq", 32'(got[REC_SEQ_LSB +: SEQ_W]), 32'(exp[REC_SEQ_LSB +: SEQ_W]));
        compare_field("src", 32'(got[REC_SRC_BIT]), 32'(exp[REC_SRC_BIT]));
        compare_field("surf", 32'(got[REC_SURF_LSB +: SURF_IDX_W]),
                      32'(exp[REC_SURF_LSB +: SURF_IDX_W]));
        compare_field("beam", 32'(got[REC_BEAM_LSB +: BEAM_W]), 32'(exp[REC_BEAM_LSB +: BEAM_W]));
        compare_field("info", 32'(got[REC_INFO_LSB +: INFO_W]), 32'(exp[REC_INFO_LSB +: INFO_W]));
        compare_field("time", got[REC_TIME_LSB +: TIME_W], exp[REC_TIME_LSB +: TIME_W]);
    endtask

    task automatic check_cnt(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %0s got %0d exp %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // one cycle, inputs move 1 ns after the edge
    task automatic step();
        @(posedge sys_clk);
        #1;
        cur_time       = cur_time + 1'b1;
        trig_dat_valid = (cur_time[1:0] == 2'b00);
        if (release_cnt > 0) begin
            credit_ret = 1'b1;
            release_cnt--;
        end else begin
            // hand back each credit as its record goes out
            credit_ret = ~hold_credit & trig_valid;
        end
    endtask

    // records checked mid-cycle, seq from the running count
    always @(negedge sys_clk) begin
        if (!runrst && trig_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected record %h at %0t with none pending", trig_rec, $time);
                err_cnt++;
            end else begin
                exp_rec = exp_q.pop_front();
                exp_rec[REC_SEQ_LSB +: SEQ_W] = rec_cnt[SEQ_W-1:0];
                check_rec(trig_rec, exp_rec);
            end
            rec_cnt++;
            test_got++;
        end
    end

    always @(posedge sys_clk) begin
        cyc_cnt++;
        if (cyc_cnt > cyc_limit) begin
            $display("timeout after %0d cycles, records still missing", cyc_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic run_test(input int k);
        logic [TIME_W-1:0] c0;
        int n_per, n_first, start_err;
        lcg_state = lcg_next(lcg_state);
        repeat (lcg_state[18:16]) step();
        // next step starts a frame
        while (cur_time[1:0] != 2'b11) step();
        c0        = cur_time + 1'b1;
        test_got  = 0;
        start_err = err_cnt;
        surf_mask = t_mask[k];
        // reference model, rf first then manual then periodic
        if ((t_flags[k] & ~t_mask[k]) != '0) begin
            exp_q.push_back(make_rec(SRC_RF, t_surf[k][SURF_IDX_W-1:0],
                t_beam[k] + BEAM_W'(t_surf[k]), t_info[k] + INFO_W'(t_surf[k]),
                c0 + TIME_W'(t_sub[k])));
        end
        if (t_man[k] != 0) begin
            exp_q.push_back(make_rec(SRC_SOFT, '0, '0, INFO_MANUAL, c0 + TIME_W'(NPHASE)));
        end
        // under hold one event waits, the rest are dropped
        n_per = t_nper[k];
        if (t_hold[k] != 0 && n_per > CREDIT_MAX + 1 - exp_q.size()) begin
            n_per = CREDIT_MAX + 1 - exp_q.size();
        end
        for (int j = 1; j <= n_per; j++) begin
            exp_q.push_back(make_rec(SRC_SOFT, '0, '0, INFO_PERIODIC,
                c0 + TIME_W'(j * t_per[k])));
        end
        hold_credit = (t_hold[k] != 0);
        for (int t = 0; t < t_frames[k] * NPHASE; t++) begin
            step();
            for (int i = 0; i < NSURF; i++) begin
                trig_dat[i] = '0;
                if (t < NPHASE && t_flags[k][i]) begin
                    trig_dat[i].hdr.flag    = 1'b1;
                    trig_dat[i].hdr.subtick = t_sub[k][2:0];
                    trig_dat[i].hdr.beam    = t_beam[k] + BEAM_W'(i);
                end else if (t >= NPHASE && t < 2 * NPHASE) begin
                    trig_dat[i].meta.info = t_info[k] + INFO_W'(i);
                end
            end
            soft_trig = (t_man[k] != 0 && t == NPHASE);
            if (t == 0) begin
                soft_period = t_per[k][PERIOD_W-1:0];
            end else if (t == t_nper[k] * t_per[k] + 1) begin
                soft_period = '0;
            end
        end
        n_first = (t_hold[k] != 0 && t_exp[k] > CREDIT_MAX) ? CREDIT_MAX : t_exp[k];
        while (test_got < n_first) step();
        repeat (2 * NPHASE) step();
        if (t_hold[k] != 0) begin
            check_cnt("records while credits held", test_got, n_first);
            hold_credit = 1'b0;
            release_cnt = 2 * CREDIT_MAX;
            while (test_got < t_exp[k]) step();
            repeat (2 * NPHASE) step();
        end
        check_cnt("records in test", test_got, t_exp[k]);
        exp_q.delete();
        $display("test %0s: %0d records, %0s", t_name[k], test_got,
                 (err_cnt == start_err) ? "ok" : "mismatch");
    endtask

    initial begin
        int fd, code, total;
        string line;
        runrst = 1'b1;
        cur_time = '0;
        trig_dat_valid = 1'b0;
        surf_mask = '0;
        soft_trig = 1'b0;
        soft_period = '0;
        credit_ret = 1'b0;
        hold_credit = 1'b0;
        for (int i = 0; i < NSURF; i++) begin
            trig_dat[i] = '0;
        end
        {n_tests, err_cnt, rec_cnt, test_got, release_cnt, cyc_cnt, total} = '0;
        cyc_limit = 100000;
        lcg_state = 32'h53cbbf77;
        fd = $fopen("tests/trig_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/trig_input.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd) && n_tests < 16) begin
                code = $fgets(line, fd);
                // skip column notes and blank lines
                if (code > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%s %d %h %h %d %h %h %d %d %d %d %d %d",
                        t_name[n_tests], t_frames[n_tests], t_mask[n_tests],
                        t_flags[n_tests], t_sub[n_tests], t_beam[n_tests],
                        t_info[n_tests], t_man[n_tests], t_per[n_tests],
                        t_nper[n_tests], t_hold[n_tests], t_exp[n_tests], t_surf[n_tests]);
                    if (code != 13) begin
                        $display("test line %0d has %0d fields, 13 needed",
                                 n_tests, code);
                        err_cnt++;
                    end else begin
                        total += t_frames[n_tests];
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        // frames of all tests plus gaps, alignment and drain
        cyc_limit = total * NPHASE + n_tests * 64 + 64;
        repeat (3) step();
        runrst = 1'b0;
        for (int k = 0; k < n_tests; k++) begin
            run_test(k);
        end
        $display("tests %0d, records %0d, errors %0d", n_tests, rec_cnt, err_cnt);
        if (err_cnt == 0 && n_tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/trig_tb_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module trig_tb_asserts import trig_pkg::*; (
    input wire logic                sys_clk,
    input wire logic                runrst,
    input wire logic                trig_valid_o,
    input wire logic [CREDIT_W-1:0] credit_q
);

    // no record without a credit
    no_send_empty: assert property (@(posedge sys_clk) disable iff (runrst)
        trig_valid_o |-> credit_q != '0)
        else $error("record sent with credit count at zero");

    // returns saturate at the grant
    credit_cap: assert property (@(posedge sys_clk) disable iff (runrst)
        credit_q <= CREDIT_W'(CREDIT_MAX))
        else $error("credit count above grant");

    // output quiet right after reset
    quiet_after_rst: assert property (@(posedge sys_clk)
        runrst |=> !trig_valid_o)
        else $error("record valid in cycle after reset");

endmodule

bind trig_merge trig_tb_asserts i_trig_tb_asserts (
    .sys_clk      (sys_clk),
    .runrst       (runrst),
    .trig_valid_o (trig_valid_o),
    .credit_q     (credit_q)
);

`default_nettype wire
